/* hw/msiptw_defs.svh */
`ifndef MSIPTW_DEFS_SVH
`define MSIPTW_DEFS_SVH

// Guest physical address width
`define MSI_GPA_W       41
// Physical address width
`define MSI_PA_W        56
// Physical page number width
`define MSI_PPN_W       44
// Page offset bits
`define MSI_PAGE_W      12
// Guest page number, also the address mask width
`define MSI_GPPN_W      29

// Fault cause code width
`define MSI_CAUSE_W     12

// MRIF address field in PTE doubleword 0
`define MSI_MRIF_ADDR_W 47
// Notice ID, split across doubleword 1
`define MSI_NID_W       11

// Each MSI PTE spans 16 bytes
`define MSI_PTE_SHIFT   4
// Read data beat width
`define MSI_BEAT_W      64

`endif

/* hw/msiptw_pkg.sv */
`include "msiptw_defs.svh"

package msiptw_pkg;

    // PTE mode field, values 0 and 2 reserved
    typedef enum logic [1:0] {
        MRIF = 2'd1,
        FLAT = 2'd3
    } msi_mode_e;

    // Fault causes reported upstream
    typedef enum logic [`MSI_CAUSE_W-1:0] {
        INSTR_ACCESS_FAULT = 1,
        PTE_INVALID        = 262,
        PTE_MISCONFIG      = 263,
        PT_DATA_CORRUPT    = 270
    } msi_cause_e;

    // Flat walker FSM
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        PROC_PTE,
        FLAT_FAULT
    } flat_state_e;

    // MRIF checker FSM
    typedef enum logic [1:0] {
        WAIT_PTE,
        NOTICE,
        MRIF_FAULT
    } mrif_state_e;

    // Doubleword 0, flat mode
    typedef struct packed {
        logic                  c;
        logic [8:0]            rsv_hi;
        logic [`MSI_PPN_W-1:0] ppn;
        logic [6:0]            rsv_lo;
        msi_mode_e             m;
        logic                  v;
    } msi_pte_flat_s;

    // Doubleword 0, MRIF mode
    // Address runs down to bit 7, so only bits 6:3 of the low reserved field remain
    typedef struct packed {
        logic                        c;
        logic [8:0]                  rsv_hi;
        logic [`MSI_MRIF_ADDR_W-1:0] addr;
        logic [3:0]                  rsv_lo;
        msi_mode_e                   m;
        logic                        v;
    } msi_pte_mrif_s;

    // Doubleword 1, notice info for MRIF mode
    typedef struct packed {
        logic [2:0]            rsv_hi;
        logic                  nid_10;
        logic [5:0]            rsv_mid;
        logic [`MSI_PPN_W-1:0] nppn;
        logic [9:0]            nid_lo;
    } msi_pte_notice_s;

endpackage

/* hw/msi_pte_addr.sv */
`timescale 1ns/100ps
`include "msiptw_defs.svh"

module msi_pte_addr (
    input  logic [`MSI_GPPN_W-1:0] gpa_i,
    input  logic [`MSI_PPN_W-1:0]  root_ppn_i,
    input  logic [`MSI_GPPN_W-1:0] mask_i,
    output logic [`MSI_PA_W-1:0]   pte_addr_o
);

    // Interrupt file number, packed toward bit 0
    logic [`MSI_GPPN_W-1:0] file_num;
    // File number scaled to a PTE byte offset
    logic [`MSI_PA_W-1:0]   file_off;

    // Gather page bits under set mask bits
    always_comb begin : extract
        int unsigned k;
        k        = 0;
        file_num = '0;
        for (int i = 0; i < `MSI_GPPN_W; i++) begin
            if (mask_i[i]) begin
                // Next free low-order slot
                file_num[k] = gpa_i[i];
                k++;
            end
        end
    end

    // 16 bytes per PTE
    assign file_off = `MSI_PA_W'(file_num) << `MSI_PTE_SHIFT;

    // Page aligned root table with the PTE offset ORed in
    assign pte_addr_o = {root_ppn_i, {`MSI_PAGE_W{1'b0}}} | file_off;

endmodule

/* hw/msi_flat_walker.sv */
`timescale 1ns/100ps
`include "msiptw_defs.svh"

module msi_flat_walker #(
    parameter bit mrif_en = 1'b1
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   trans_req_i,
    input  logic                   is_rx_i,
    input  logic [`MSI_PA_W-1:0]   pte_addr_i,
    input  logic                   mrif_busy_i,
    input  logic                   rd_valid_i,
    input  logic [`MSI_BEAT_W-1:0] rd_data_i,
    input  logic                   rd_err_i,
    input  logic                   rd_last_i,
    output logic                   rd_req_o,
    output logic [`MSI_PA_W-1:0]   rd_addr_o,
    output logic                   flat_update_o,
    output logic [`MSI_PPN_W-1:0]  flat_ppn_o,
    output logic                   mrif_start_o,
    output logic                   busy_o,
    output logic                   fault_o,
    output msiptw_pkg::msi_cause_e cause_o
);

    msiptw_pkg::flat_state_e state_q, state_d;
    msiptw_pkg::msi_cause_e  cause_q, cause_d;

    // Fault entered mid-burst, beat 1 still outstanding
    logic wait_last_q, wait_last_d;

    // PTE address captured at acceptance
    logic [`MSI_PA_W-1:0] addr_q;

    // Live beat seen as doubleword 0
    msiptw_pkg::msi_pte_flat_s pte;

    logic accept;

    assign pte = rd_data_i;

    // New request only when both engines are idle
    assign accept = (state_q == msiptw_pkg::IDLE) && trans_req_i && !mrif_busy_i;

    assign rd_req_o   = (state_q == msiptw_pkg::FETCH);
    assign rd_addr_o  = addr_q;
    assign flat_ppn_o = pte.ppn;
    assign busy_o     = (state_q != msiptw_pkg::IDLE);
    assign fault_o    = (state_q == msiptw_pkg::FLAT_FAULT);
    assign cause_o    = cause_q;

    always_comb begin : next_state
        state_d       = state_q;
        cause_d       = cause_q;
        wait_last_d   = wait_last_q;
        flat_update_o = 1'b0;
        mrif_start_o  = 1'b0;

        case (state_q)
            msiptw_pkg::IDLE: begin
                wait_last_d = 1'b0;
                if (accept) begin
                    // Execute access to an MSI page is never allowed
                    if (is_rx_i) begin
                        cause_d = msiptw_pkg::INSTR_ACCESS_FAULT;
                        state_d = msiptw_pkg::FLAT_FAULT;
                    end else begin
                        state_d = msiptw_pkg::FETCH;
                    end
                end
            end

            // Single cycle read strobe
            msiptw_pkg::FETCH: begin
                state_d = msiptw_pkg::PROC_PTE;
            end

            // Beat 0 carries doubleword 0
            msiptw_pkg::PROC_PTE: begin
                if (rd_valid_i) begin
                    // Assume a fault, cleared below on success
                    wait_last_d = 1'b1;
                    // Custom format (C set) treated as invalid
                    if (!pte.v || pte.c) begin
                        cause_d = msiptw_pkg::PTE_INVALID;
                        state_d = msiptw_pkg::FLAT_FAULT;
                    end else if (rd_err_i) begin
                        cause_d = msiptw_pkg::PT_DATA_CORRUPT;
                        state_d = msiptw_pkg::FLAT_FAULT;
                    end else begin
                        case (pte.m)
                            msiptw_pkg::MRIF: begin
                                if (mrif_en) begin
                                    // Hand over, checker consumes beat 1
                                    mrif_start_o = 1'b1;
                                    wait_last_d  = 1'b0;
                                    state_d      = msiptw_pkg::IDLE;
                                end else begin
                                    cause_d = msiptw_pkg::PTE_MISCONFIG;
                                    state_d = msiptw_pkg::FLAT_FAULT;
                                end
                            end
                            msiptw_pkg::FLAT: begin
                                if ((|pte.rsv_lo) || (|pte.rsv_hi)) begin
                                    cause_d = msiptw_pkg::PTE_MISCONFIG;
                                    state_d = msiptw_pkg::FLAT_FAULT;
                                end else begin
                                    // Beat 1 unused in flat mode
                                    flat_update_o = 1'b1;
                                    wait_last_d   = 1'b0;
                                    state_d       = msiptw_pkg::IDLE;
                                end
                            end
                            // Reserved modes
                            default: begin
                                cause_d = msiptw_pkg::PTE_MISCONFIG;
                                state_d = msiptw_pkg::FLAT_FAULT;
                            end
                        endcase
                    end
                end
            end

            // Hold fault until the burst has drained
            msiptw_pkg::FLAT_FAULT: begin
                if (!wait_last_q || (rd_valid_i && rd_last_i)) begin
                    state_d = msiptw_pkg::IDLE;
                end
            end

            default: begin
                state_d = msiptw_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            state_q     <= msiptw_pkg::IDLE;
            wait_last_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            wait_last_q <= wait_last_d;
        end
    end

    // Fault cause and PTE address of the accepted request
    always_ff @(posedge clk_i) begin : data_regs
        cause_q <= cause_d;
        if (accept) begin
            addr_q <= pte_addr_i;
        end
    end

endmodule

/* hw/msi_mrif_checker.sv */
`timescale 1ns/100ps
`include "msiptw_defs.svh"

module msi_mrif_checker (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        mrif_start_i,
    input  logic [`MSI_PAGE_W-1:0]      page_offset_i,
    input  logic                        rd_valid_i,
    input  logic [`MSI_BEAT_W-1:0]      rd_data_i,
    input  logic                        rd_err_i,
    input  logic                        rd_last_i,
    output logic                        mrif_update_o,
    output logic [`MSI_MRIF_ADDR_W-1:0] mrif_addr_o,
    output logic [`MSI_NID_W-1:0]       mrif_nid_o,
    output logic [`MSI_PPN_W-1:0]       mrif_nppn_o,
    output logic                        ignore_o,
    output logic                        busy_o,
    output logic                        fault_o,
    output msiptw_pkg::msi_cause_e      cause_o
);

    msiptw_pkg::mrif_state_e state_q, state_d;
    msiptw_pkg::msi_cause_e  cause_q, cause_d;

    logic wait_last_q, wait_last_d;

    // MRIF address from doubleword 0, held for the update
    logic [`MSI_MRIF_ADDR_W-1:0] addr_q;
    logic                        addr_en;

    // Same beat, two views
    msiptw_pkg::msi_pte_mrif_s   pte;
    msiptw_pkg::msi_pte_notice_s ntc;

    assign pte = rd_data_i;
    assign ntc = rd_data_i;

    assign mrif_addr_o = addr_q;
    // Notice fields straight off beat 1
    assign mrif_nid_o  = {ntc.nid_10, ntc.nid_lo};
    assign mrif_nppn_o = ntc.nppn;

    assign busy_o  = (state_q != msiptw_pkg::WAIT_PTE);
    assign fault_o = (state_q == msiptw_pkg::MRIF_FAULT);
    assign cause_o = cause_q;

    always_comb begin : next_state
        state_d       = state_q;
        cause_d       = cause_q;
        wait_last_d   = wait_last_q;
        addr_en       = 1'b0;
        mrif_update_o = 1'b0;
        ignore_o      = 1'b0;

        case (state_q)
            // Start arrives with beat 0 on the bus
            msiptw_pkg::WAIT_PTE: begin
                if (mrif_start_i) begin
                    wait_last_d = 1'b1;
                    if (rd_err_i) begin
                        cause_d = msiptw_pkg::PT_DATA_CORRUPT;
                        state_d = msiptw_pkg::MRIF_FAULT;
                    end else if ((|pte.rsv_lo) || (|pte.rsv_hi)) begin
                        cause_d = msiptw_pkg::PTE_MISCONFIG;
                        state_d = msiptw_pkg::MRIF_FAULT;
                    end else if (|page_offset_i) begin
                        // Only aligned writes reach an MRIF, drop quietly
                        ignore_o    = 1'b1;
                        wait_last_d = 1'b0;
                    end else begin
                        addr_en = 1'b1;
                        state_d = msiptw_pkg::NOTICE;
                    end
                end
            end

            // Beat 1 carries the notice doubleword
            msiptw_pkg::NOTICE: begin
                if (rd_valid_i) begin
                    wait_last_d = !rd_last_i;
                    if (rd_err_i) begin
                        cause_d = msiptw_pkg::PT_DATA_CORRUPT;
                        state_d = msiptw_pkg::MRIF_FAULT;
                    end else if ((|ntc.rsv_hi) || (|ntc.rsv_mid)) begin
                        cause_d = msiptw_pkg::PTE_MISCONFIG;
                        state_d = msiptw_pkg::MRIF_FAULT;
                    end else begin
                        mrif_update_o = 1'b1;
                        state_d       = msiptw_pkg::WAIT_PTE;
                    end
                end
            end

            msiptw_pkg::MRIF_FAULT: begin
                if (!wait_last_q || (rd_valid_i && rd_last_i)) begin
                    state_d = msiptw_pkg::WAIT_PTE;
                end
            end

            default: begin
                state_d = msiptw_pkg::WAIT_PTE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            state_q     <= msiptw_pkg::WAIT_PTE;
            wait_last_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            wait_last_q <= wait_last_d;
        end
    end

    always_ff @(posedge clk_i) begin : data_regs
        cause_q <= cause_d;
        if (addr_en) begin
            addr_q <= pte.addr;
        end
    end

endmodule

/* hw/msiptw_top.sv */
`timescale 1ns/100ps
`include "msiptw_defs.svh"

module msiptw_top #(
    parameter bit mrif_en = 1'b1
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        trans_req_i,
    input  logic [`MSI_GPA_W-1:0]       gpa_i,
    input  logic                        is_rx_i,
    input  logic [`MSI_PPN_W-1:0]       root_ppn_i,
    input  logic [`MSI_GPPN_W-1:0]      mask_i,
    input  logic                        rd_valid_i,
    input  logic [`MSI_BEAT_W-1:0]      rd_data_i,
    input  logic                        rd_err_i,
    input  logic                        rd_last_i,
    output logic                        rd_req_o,
    output logic [`MSI_PA_W-1:0]        rd_addr_o,
    output logic                        active_o,
    output logic                        flat_update_o,
    output logic [`MSI_PPN_W-1:0]       flat_ppn_o,
    output logic                        mrif_update_o,
    output logic [`MSI_MRIF_ADDR_W-1:0] mrif_addr_o,
    output logic [`MSI_NID_W-1:0]       mrif_nid_o,
    output logic [`MSI_PPN_W-1:0]       mrif_nppn_o,
    output logic                        ignore_o,
    output logic                        fault_o,
    output logic [`MSI_CAUSE_W-1:0]     cause_o
);

    logic [`MSI_PA_W-1:0]   pte_addr;
    logic                   mrif_start;
    logic                   flat_busy, flat_fault;
    logic                   mrif_busy, mrif_fault;
    msiptw_pkg::msi_cause_e flat_cause, mrif_cause;

    // PTE address from the GPA page number
    msi_pte_addr i_pte_addr (
        .gpa_i      (gpa_i[`MSI_GPA_W-1:`MSI_PAGE_W]),
        .root_ppn_i (root_ppn_i),
        .mask_i     (mask_i),
        .pte_addr_o (pte_addr)
    );

    msi_flat_walker #(
        .mrif_en (mrif_en)
    ) i_flat (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .trans_req_i   (trans_req_i),
        .is_rx_i       (is_rx_i),
        .pte_addr_i    (pte_addr),
        .mrif_busy_i   (mrif_busy),
        .rd_valid_i    (rd_valid_i),
        .rd_data_i     (rd_data_i),
        .rd_err_i      (rd_err_i),
        .rd_last_i     (rd_last_i),
        .rd_req_o      (rd_req_o),
        .rd_addr_o     (rd_addr_o),
        .flat_update_o (flat_update_o),
        .flat_ppn_o    (flat_ppn_o),
        .mrif_start_o  (mrif_start),
        .busy_o        (flat_busy),
        .fault_o       (flat_fault),
        .cause_o       (flat_cause)
    );

    if (mrif_en) begin : gen_mrif
        // Access offset kept from the accepted request
        logic [`MSI_PAGE_W-1:0] offset_q;

        always_ff @(posedge clk_i) begin : offset_reg
            if (trans_req_i && !active_o) begin
                offset_q <= gpa_i[`MSI_PAGE_W-1:0];
            end
        end

        msi_mrif_checker i_mrif (
            .clk_i         (clk_i),
            .rst_ni        (rst_ni),
            .mrif_start_i  (mrif_start),
            .page_offset_i (offset_q),
            .rd_valid_i    (rd_valid_i),
            .rd_data_i     (rd_data_i),
            .rd_err_i      (rd_err_i),
            .rd_last_i     (rd_last_i),
            .mrif_update_o (mrif_update_o),
            .mrif_addr_o   (mrif_addr_o),
            .mrif_nid_o    (mrif_nid_o),
            .mrif_nppn_o   (mrif_nppn_o),
            .ignore_o      (ignore_o),
            .busy_o        (mrif_busy),
            .fault_o       (mrif_fault),
            .cause_o       (mrif_cause)
        );
    end else begin : gen_no_mrif
        // Walker faults MRIF PTEs itself, nothing to report here
        assign mrif_update_o = 1'b0;
        assign mrif_addr_o   = '0;
        assign mrif_nid_o    = '0;
        assign mrif_nppn_o   = '0;
        assign ignore_o      = 1'b0;
        assign mrif_busy     = 1'b0;
        assign mrif_fault    = 1'b0;
        assign mrif_cause    = msiptw_pkg::msi_cause_e'(0);
    end

    assign active_o = flat_busy | mrif_busy;
    assign fault_o  = flat_fault | mrif_fault;

    // Flat cause wins, engines never fault together
    assign cause_o = flat_fault ? flat_cause :
                     mrif_fault ? mrif_cause : '0;

endmodule

/* tests/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int half_period_ns = 2
) (
    output logic clk_o
);

    // 4 ns period with the default half period
    initial begin : toggle
        clk_o = 1'b0;
        forever begin
            #(half_period_ns) clk_o = ~clk_o;
        end
    end

endmodule

/* tests/msiptw_mem_model.sv */
`timescale 1ns/100ps
`include "msiptw_defs.svh"

module msiptw_mem_model #(
    parameter int latency = 3
) (
    input  logic                   clk_i,
    input  logic                   rd_req_i,
    input  logic [`MSI_BEAT_W-1:0] dw0_i,
    input  logic [`MSI_BEAT_W-1:0] dw1_i,
    input  logic                   err0_i,
    input  logic                   err1_i,
    output logic                   rd_valid_o,
    output logic [`MSI_BEAT_W-1:0] rd_data_o,
    output logic                   rd_err_o,
    output logic                   rd_last_o,
    output logic                   busy_o
);

    // One beat on the bus, 1 ns after the edge
    task automatic drive_beat(input logic [`MSI_BEAT_W-1:0] data, input logic err,
                              input logic last);
        rd_valid_o = 1'b1;
        rd_data_o  = data;
        rd_err_o   = err;
        rd_last_o  = last;
    endtask

    initial begin : serve
        rd_valid_o = 1'b0;
        rd_data_o  = '0;
        rd_err_o   = 1'b0;
        rd_last_o  = 1'b0;
        busy_o     = 1'b0;
        forever begin
            // Strobe is stable by mid-cycle
            @(negedge clk_i);
            if (rd_req_i) begin
                busy_o = 1'b1;
                repeat (latency) @(posedge clk_i);
                #1;
                drive_beat(dw0_i, err0_i, 1'b0);
                @(posedge clk_i);
                #1;
                drive_beat(dw1_i, err1_i, 1'b1);
                @(posedge clk_i);
                #1;
                drive_beat('0, 1'b0, 1'b0);
                rd_valid_o = 1'b0;
                busy_o     = 1'b0;
            end
        end
    end

endmodule

/* tests/msiptw_tb.sv */
`timescale 1ns/100ps
`include "msiptw_defs.svh"

module msiptw_tb;

    localparam int N_CASES      = 15;
    localparam int ROUNDS       = 4;
    localparam int IDLE_TIMEOUT = 40;
    // Expected outcome of one request
    localparam int K_FLAT   = 0;
    localparam int K_MRIF   = 1;
    localparam int K_IGNORE = 2;
    localparam int K_FAULT  = 3;

    logic                        clk, rst_n, trans_req, is_rx;
    logic [`MSI_GPA_W-1:0]       gpa;
    logic [`MSI_PPN_W-1:0]       root_ppn;
    logic [`MSI_GPPN_W-1:0]      mask;
    logic                        rd_valid, rd_err, rd_last, rd_req, active;
    logic [`MSI_BEAT_W-1:0]      rd_data;
    logic [`MSI_PA_W-1:0]        rd_addr;
    logic                        flat_update, mrif_update, ignore, fault;
    logic [`MSI_PPN_W-1:0]       flat_ppn, mrif_nppn;
    logic [`MSI_MRIF_ADDR_W-1:0] mrif_addr;
    logic [`MSI_NID_W-1:0]       mrif_nid;
    logic [`MSI_CAUSE_W-1:0]     cause;
    // Memory contents for the current request
    logic [`MSI_BEAT_W-1:0]      dw0, dw1;
    logic                        err0, err1, mem_busy;

    int                          exp_kind = -1;
    int                          exp_cause = 0;
    logic [`MSI_PA_W-1:0]        exp_addr = '0;
    logic [`MSI_PPN_W-1:0]       exp_ppn = '0;
    logic [`MSI_PPN_W-1:0]       exp_nppn = '0;
    logic [`MSI_MRIF_ADDR_W-1:0] exp_maddr = '0;
    logic [`MSI_NID_W-1:0]       exp_nid = '0;
    int seed = 88198;
    int err_count = 0;
    int timeout_count = 0;
    int cases_run = 0;
    int cur_case = 0;
    bit hung = 1'b0;
    int n_reads, n_flat_upd, n_mrif_upd, n_ignore, n_fault_cyc;

    tb_clkgen i_clkgen (.clk_o(clk));

    msiptw_mem_model #(.latency(3)) i_mem (
        .clk_i(clk), .rd_req_i(rd_req), .dw0_i(dw0), .dw1_i(dw1), .err0_i(err0),
        .err1_i(err1), .rd_valid_o(rd_valid), .rd_data_o(rd_data), .rd_err_o(rd_err),
        .rd_last_o(rd_last), .busy_o(mem_busy)
    );

    msiptw_top #(.mrif_en(1'b1)) i_dut (
        .clk_i(clk), .rst_ni(rst_n), .trans_req_i(trans_req), .gpa_i(gpa), .is_rx_i(is_rx),
        .root_ppn_i(root_ppn), .mask_i(mask), .rd_valid_i(rd_valid), .rd_data_i(rd_data),
        .rd_err_i(rd_err), .rd_last_i(rd_last), .rd_req_o(rd_req), .rd_addr_o(rd_addr),
        .active_o(active), .flat_update_o(flat_update), .flat_ppn_o(flat_ppn),
        .mrif_update_o(mrif_update), .mrif_addr_o(mrif_addr), .mrif_nid_o(mrif_nid),
        .mrif_nppn_o(mrif_nppn), .ignore_o(ignore), .fault_o(fault), .cause_o(cause)
    );

    task automatic log_error(input string msg);
        err_count++;
        $display("[ERROR] %0d ns: %s", $time, msg);
    endtask

    // File number: masked page bits packed toward bit 0, 16 bytes per PTE
    function automatic logic [`MSI_PA_W-1:0] ref_pte_addr(input logic [`MSI_GPA_W-1:0] a,
            input logic [`MSI_PPN_W-1:0] root, input logic [`MSI_GPPN_W-1:0] m);
        logic [`MSI_GPPN_W-1:0] page;
        logic [`MSI_PA_W-1:0]   file_num;
        int                     pos;
        page     = a[`MSI_GPA_W-1:`MSI_PAGE_W];
        file_num = '0;
        pos      = 0;
        for (int b = 0; b < `MSI_GPPN_W; b++) begin
            if (m[b]) begin
                file_num[pos] = page[b];
                pos++;
            end
        end
        return ({root, {`MSI_PAGE_W{1'b0}}}) | (file_num << `MSI_PTE_SHIFT);
    endfunction

    a_addr: assert property (@(posedge clk) disable iff (!rst_n) rd_req |-> rd_addr == exp_addr)
        else log_error("read address differs from reference PTE address");
    a_read: assert property (@(posedge clk) disable iff (!rst_n)
        trans_req && !active && !is_rx |=> rd_req)
        else log_error("no read strobe in the cycle after the trigger");
    a_rx: assert property (@(posedge clk) disable iff (!rst_n)
        trans_req && !active && is_rx |=> fault && cause == 1 && !rd_req)
        else log_error("execute request did not fault at once with cause 1");
    a_busy: assert property (@(posedge clk) disable iff (!rst_n) trans_req && !active |=> active)
        else log_error("active_o did not rise after acceptance");
    a_flat: assert property (@(posedge clk) disable iff (!rst_n)
        flat_update |-> exp_kind == K_FLAT && flat_ppn == exp_ppn && !fault)
        else log_error("unexpected flat update or wrong PPN");
    a_mrif: assert property (@(posedge clk) disable iff (!rst_n)
        mrif_update |-> exp_kind == K_MRIF && mrif_addr == exp_maddr && mrif_nid == exp_nid
                        && mrif_nppn == exp_nppn && !fault)
        else log_error("unexpected MRIF update or wrong fields");
    a_ignore: assert property (@(posedge clk) disable iff (!rst_n)
        ignore |-> exp_kind == K_IGNORE && !fault && !mrif_update)
        else log_error("unexpected ignore strobe");
    a_fault: assert property (@(posedge clk) disable iff (!rst_n)
        fault |-> exp_kind == K_FAULT && cause == exp_cause)
        else log_error("unexpected fault or wrong cause");

    // Random request plus PTE doublewords for one case
    task automatic setup_case(input int idx);
        int unsigned pick;
        gpa       = `MSI_GPA_W'({$random(seed), $random(seed)});
        mask      = `MSI_GPPN_W'($random(seed));
        root_ppn  = `MSI_PPN_W'({$random(seed), $random(seed)});
        exp_ppn   = `MSI_PPN_W'({$random(seed), $random(seed)});
        exp_maddr = `MSI_MRIF_ADDR_W'({$random(seed), $random(seed)});
        exp_nid   = `MSI_NID_W'($random(seed));
        exp_nppn  = `MSI_PPN_W'({$random(seed), $random(seed)});
        pick      = $unsigned($random(seed));
        is_rx     = 1'b0;
        err0      = 1'b0;
        err1      = 1'b0;
        exp_kind  = K_FAULT;
        exp_cause = 263;
        // Flat: C, rsv 62:54, PPN, rsv 9:3, M, V
        dw0 = {1'b0, 9'd0, exp_ppn, 7'd0, 2'd3, 1'b1};
        // Notice: rsv, nid[10] at bit 60, rsv, notice PPN, nid[9:0]
        dw1 = {3'd0, exp_nid[10], 6'd0, exp_nppn, exp_nid[9:0]};
        if (idx >= 8) begin
            // MRIF mode, address at 53:7, aligned access
            dw0 = {1'b0, 9'd0, exp_maddr, 4'd0, 2'd1, 1'b1};
            gpa[`MSI_PAGE_W-1:0] = '0;
        end
        case (idx)
            0:  exp_kind = K_FLAT;
            // V clear
            1: begin
                dw0[0]    = 1'b0;
                exp_cause = 262;
            end
            // C set
            2: begin
                dw0[63]   = 1'b1;
                exp_cause = 262;
            end
            3:  dw0[3 + pick % 7] = 1'b1;
            4:  dw0[54 + pick % 9] = 1'b1;
            5:  dw0[2:1] = 2'd0;
            6:  dw0[2:1] = 2'd2;
            7: begin
                err0      = 1'b1;
                exp_cause = 270;
            end
            8:  exp_kind = K_MRIF;
            // Unaligned MRIF access
            9: begin
                gpa[`MSI_PAGE_W-1:0] = `MSI_PAGE_W'(pick) | 12'h1;
                exp_kind             = K_IGNORE;
            end
            10: dw0[3 + pick % 4] = 1'b1;
            11: dw0[54 + pick % 9] = 1'b1;
            // Reserved bits of doubleword 1, 59:54 or 63:61
            12: dw1[(pick % 2) ? (54 + (pick / 2) % 6) : (61 + pick % 3)] = 1'b1;
            13: begin
                err1      = 1'b1;
                exp_cause = 270;
            end
            default: begin
                is_rx     = 1'b1;
                exp_cause = 1;
            end
        endcase
        exp_addr = ref_pte_addr(gpa, root_ppn, mask);
    endtask

    // Count events every cycle until DUT and memory are both idle
    task automatic watch_until_idle();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            if (rd_req) n_reads++;
            if (flat_update) n_flat_upd++;
            if (mrif_update) n_mrif_upd++;
            if (ignore) n_ignore++;
            if (fault) n_fault_cyc++;
            cycles++;
        end while ((active || mem_busy) && cycles < IDLE_TIMEOUT);
        if (active || mem_busy) begin
            $display("Timeout: DUT still busy %0d cycles into case %0d", cycles, cur_case);
            timeout_count++;
            hung = 1'b1;
        end
    endtask

    task automatic run_case(input int idx);
        @(posedge clk);
        #1;
        cur_case    = idx;
        n_reads     = 0;
        n_flat_upd  = 0;
        n_mrif_upd  = 0;
        n_ignore    = 0;
        n_fault_cyc = 0;
        setup_case(idx);
        trans_req = 1'b1;
        @(posedge clk);
        #1;
        trans_req = 1'b0;
        watch_until_idle();
        cases_run++;
        if (!hung) begin
            assert (n_reads == (is_rx ? 0 : 1))
                else log_error($sformatf("case %0d: %0d read strobes", idx, n_reads));
            assert (n_flat_upd == (exp_kind == K_FLAT ? 1 : 0))
                else log_error($sformatf("case %0d: %0d flat updates", idx, n_flat_upd));
            assert (n_mrif_upd == (exp_kind == K_MRIF ? 1 : 0))
                else log_error($sformatf("case %0d: %0d MRIF updates", idx, n_mrif_upd));
            assert (n_ignore == (exp_kind == K_IGNORE ? 1 : 0))
                else log_error($sformatf("case %0d: %0d ignore strobes", idx, n_ignore));
            // Beats come back to back, so any fault lasts a single cycle
            assert (n_fault_cyc == (exp_kind == K_FAULT ? 1 : 0))
                else log_error($sformatf("case %0d: fault held %0d cycles", idx, n_fault_cyc));
        end
    endtask

    task automatic end_run();
        $display("Checks failed: %0d, timeouts: %0d, cases run: %0d",
                 err_count, timeout_count, cases_run);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin : main
        rst_n     = 1'b0;
        trans_req = 1'b0;
        is_rx     = 1'b0;
        gpa       = '0;
        root_ppn  = '0;
        mask      = '0;
        dw0       = '0;
        dw1       = '0;
        err0      = 1'b0;
        err1      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!rd_req && !flat_update && !mrif_update && !ignore && !fault && !active)
            else log_error("outputs not idle after reset");
        for (int r = 0; r < ROUNDS && !hung; r++) begin
            for (int c = 0; c < N_CASES && !hung; c++) begin
                run_case(c);
            end
        end
        end_run();
    end

endmodule

/* msiptw.f */
+incdir+hw
hw/msiptw_pkg.sv
hw/msi_pte_addr.sv
hw/msi_flat_walker.sv
hw/msi_mrif_checker.sv
hw/msiptw_top.sv
tests/tb_clkgen.sv
tests/msiptw_mem_model.sv
tests/msiptw_tb.sv
